/* otp_lci.f */
verilog/otp_lci_pkg.sv
verilog/otp_lci_word_cnt.sv
verilog/otp_lci_fsm.sv
verilog/otp_array.sv
verilog/otp_lci_top.sv
test/otp_lci_tb.sv

/* test/otp_lci_tb.sv */
// Testbench for the OTP life cycle programming path that drives otp_lci_top as the DUT
`default_nettype none
`timescale 1ns/1ps

module otp_lci_tb;

  import otp_lci_pkg::*;

  // Expected cycles from the request edge to the acknowledge
  localparam int AckLatency    = 13;
  localparam int AckLimit      = 40;
  localparam int NumRandXfers  = 8;
  // 40 transfers of 13 cycles plus margin
  localparam int TimeoutCycles = 40 * 13 + 200;

  logic      clk_i;
  logic      rst_ni;
  logic      lci_en_i;
  lc_tx_t    escalate_en_i;
  logic      lc_req_i;
  lc_data_t  lc_data_i;
  logic      lc_ack_o;
  logic      lc_err_o;
  otp_err_e  error_o;
  logic      fsm_err_o;
  logic      lci_prog_idle_o;
  otp_addr_t dbg_addr_i;
  otp_word_t dbg_rdata_o;

  // Shadow copy of the array contents
  otp_word_t   shadow [OtpDepth];
  int          errors;
  int          checks;
  int          cycle_cnt;
  logic        exp_err;
  logic        ack_allowed;
  logic        fsm_err_allowed;
  int          lat;
  lc_data_t    data;
  otp_word_t   rnd_word;

  otp_lci_top dut0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lci_en_i        (lci_en_i),
    .escalate_en_i   (escalate_en_i),
    .lc_req_i        (lc_req_i),
    .lc_data_i       (lc_data_i),
    .lc_ack_o        (lc_ack_o),
    .lc_err_o        (lc_err_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .lci_prog_idle_o (lci_prog_idle_o),
    .dbg_addr_i      (dbg_addr_i),
    .dbg_rdata_o     (dbg_rdata_o)
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Reference model and compare tasks
  ////////////////////////////////////////

  // Updates the shadow with the OR of old and new and returns the expected error flag
  function automatic logic predict_transfer(input lc_data_t d);
    otp_word_t w;
    otp_word_t old;
    logic      err;
    err = 1'b0;
    for (int k = 0; k < NumLcWords; k++) begin
      w   = d[OtpWidth*k +: OtpWidth];
      old = shadow[LcOffset+k];
      // A programmed bit that the new word clears
      if ((old & ~w) != '0) begin
        err = 1'b1;
      end
      shadow[LcOffset+k] = old | w;
    end
    return err;
  endfunction

  task automatic check_word(input string what, input otp_word_t got, input otp_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input string what, input otp_err_e got, input otp_err_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s: got code %0d expected code %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s: got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_latency(input int got);
    checks++;
    if (got != AckLatency) begin
      errors++;
      $display("ERR %0t ack latency: got %0d cycles expected %0d", $time, got, AckLatency);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni   <= 1'b0;
    lci_en_i <= 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < OtpDepth; i++) begin
      shadow[i] = '0;
    end
  endtask

  // Raise the request and count negedges up to the acknowledge
  task automatic run_transfer(input lc_data_t d, output int cycles);
    logic got;
    got    = 1'b0;
    cycles = 0;
    @(posedge clk_i);
    lc_data_i <= d;
    lc_req_i  <= 1'b1;
    while (!got && cycles < AckLimit) begin
      @(negedge clk_i);
      cycles++;
      got = lc_ack_o;
    end
    if (!got) begin
      errors++;
      $display("No acknowledge within %0d cycles of the request", AckLimit);
    end
    // Drop the request on the edge that leaves the ack cycle
    @(posedge clk_i);
    lc_req_i <= 1'b0;
  endtask

  // Request that must stay unanswered while the FSM is locked
  task automatic expect_no_ack(input lc_data_t d);
    ack_allowed = 1'b0;
    @(posedge clk_i);
    lc_data_i <= d;
    lc_req_i  <= 1'b1;
    repeat (30) begin
      @(negedge clk_i);
      check_bit("lci_prog_idle_o while locked", lci_prog_idle_o, 1'b1);
    end
    @(posedge clk_i);
    lc_req_i <= 1'b0;
  endtask

  // Compare the life cycle words on the debug port with the shadow
  task automatic check_lc_words();
    for (int k = 0; k < NumLcWords; k++) begin
      @(posedge clk_i);
      dbg_addr_i <= otp_addr_t'(LcOffset + k);
      @(negedge clk_i);
      check_word($sformatf("word %0d", LcOffset + k), dbg_rdata_o, shadow[LcOffset+k]);
    end
  endtask

  ////////////////////////////////////////
  // Response checker
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (lc_ack_o && !ack_allowed) begin
        errors++;
        $display("Acknowledge seen while the FSM should be locked");
      end else if (lc_ack_o) begin
        check_bit("lc_err_o", lc_err_o, exp_err);
      end
      if (lc_err_o && !lc_ack_o) begin
        errors++;
        $display("lc_err_o pulsed without lc_ack_o");
      end
      if (fsm_err_o && !fsm_err_allowed) begin
        errors++;
        $display("Unexpected fsm_err_o pulse");
      end
    end
  end

  // Hang guard
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Run stopped by timeout after %0d cycles", cycle_cnt);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    lci_en_i        = 1'b0;
    escalate_en_i   = LcTxOff;
    lc_req_i        = 1'b0;
    lc_data_i       = '0;
    dbg_addr_i      = '0;
    errors          = 0;
    checks          = 0;
    cycle_cnt       = 0;
    exp_err         = 1'b0;
    ack_allowed     = 1'b1;
    fsm_err_allowed = 1'b0;
    void'($urandom(32'h815cb275));

    // Reset state and enable
    apply_reset();
    @(negedge clk_i);
    check_bit("lci_prog_idle_o after reset", lci_prog_idle_o, 1'b0);
    check_err("error_o after reset", error_o, NoError);
    @(posedge clk_i);
    lci_en_i <= 1'b1;
    @(negedge clk_i);
    check_bit("lci_prog_idle_o before enable seen", lci_prog_idle_o, 1'b0);
    @(negedge clk_i);
    check_bit("lci_prog_idle_o after enable", lci_prog_idle_o, 1'b1);

    // Blank words
    data    = 64'ha5a5_3c3c_0f0f_8001;
    exp_err = predict_transfer(data);
    run_transfer(data, lat);
    check_latency(lat);
    check_lc_words();

    // Random transfers that only add bits
    for (int t = 0; t < NumRandXfers; t++) begin
      for (int k = 0; k < NumLcWords; k++) begin
        rnd_word = otp_word_t'($urandom) & otp_word_t'($urandom);
        data[OtpWidth*k +: OtpWidth] = shadow[LcOffset+k] | rnd_word;
      end
      exp_err = predict_transfer(data);
      run_transfer(data, lat);
      check_latency(lat);
      check_lc_words();
    end

    // Word 2 inverted clears its programmed bits
    for (int k = 0; k < NumLcWords; k++) begin
      data[OtpWidth*k +: OtpWidth] = (k == 2) ? ~shadow[LcOffset+k] : shadow[LcOffset+k];
    end
    exp_err = predict_transfer(data);
    run_transfer(data, lat);
    @(negedge clk_i);
    check_err("error_o after blank error", error_o, MacroWriteBlankError);
    check_lc_words();
    expect_no_ack(~data);
    check_lc_words();

    // Escalation after a fresh reset
    apply_reset();
    ack_allowed = 1'b1;
    lci_en_i <= 1'b1;
    repeat (3) @(posedge clk_i);
    fsm_err_allowed = 1'b1;
    escalate_en_i <= LcTxOn;
    @(negedge clk_i);
    check_bit("fsm_err_o on escalation", fsm_err_o, 1'b1);
    @(negedge clk_i);
    check_bit("fsm_err_o after escalation", fsm_err_o, 1'b0);
    check_err("error_o after escalation", error_o, FsmStateError);
    fsm_err_allowed = 1'b0;
    expect_no_ack({$urandom, $urandom});
    check_lc_words();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : otp_lci_tb

`default_nettype wire

/* verilog/otp_array.sv */
// OTP array model with a single-write port, fixed response latency and a debug read port
`default_nettype none
`timescale 1ns/1ps

module otp_array (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Write port
  input  logic                   req_i,
  output logic                   gnt_o,
  input  otp_lci_pkg::otp_addr_t addr_i,
  input  otp_lci_pkg::otp_word_t wdata_i,
  output logic                   rvalid_o,
  output otp_lci_pkg::otp_err_e  err_o,
  // Combinational debug read
  input  otp_lci_pkg::otp_addr_t dbg_addr_i,
  output otp_lci_pkg::otp_word_t dbg_rdata_o
);

  import otp_lci_pkg::*;

  // Stored words
  otp_word_t mem_q [OtpDepth];

  // Response pipeline with one stage per latency cycle
  logic [OtpRespLatency-1:0] valid_q;
  otp_err_e                  err_q [OtpRespLatency];

  // Write accepted in this cycle
  logic     wr_en;
  // Error of the accepted write
  otp_err_e wr_err;

  ////////////////////////////////////////
  // Write acceptance
  ////////////////////////////////////////

  // Grant only while no write is in flight
  assign gnt_o = ~|valid_q;
  assign wr_en = req_i & gnt_o;

  // Clearing a programmed bit is not possible
  always_comb begin
    wr_err = NoError;
    if ((mem_q[addr_i] & ~wdata_i) != '0) begin
      wr_err = MacroWriteBlankError;
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Bits can only move from 0 to 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < OtpDepth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      mem_q[addr_i] <= mem_q[addr_i] | wdata_i;
    end
  end

  ////////////////////////////////////////
  // Response delay
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= wr_en;
      for (int i = 1; i < OtpRespLatency; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Error code travels alongside the valid bit
  always_ff @(posedge clk_i) begin
    err_q[0] <= wr_err;
    for (int i = 1; i < OtpRespLatency; i++) begin
      err_q[i] <= err_q[i-1];
    end
  end

  assign rvalid_o = valid_q[OtpRespLatency-1];
  assign err_o    = err_q[OtpRespLatency-1];

  // Debug view of the array
  assign dbg_rdata_o = mem_q[dbg_addr_i];

endmodule : otp_array

`default_nettype wire

/* verilog/otp_lci_fsm.sv */
// Life cycle programming controller that burns the transition data word by word into the OTP array
`default_nettype none
`timescale 1ns/1ps

module otp_lci_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   lci_en_i,
  // Any escalation value but LcTxOff locks the FSM
  input  otp_lci_pkg::lc_tx_t    escalate_en_i,
  // Transition request from the life cycle controller
  input  logic                   lc_req_i,
  input  otp_lci_pkg::lc_data_t  lc_data_i,
  output logic                   lc_ack_o,
  output logic                   lc_err_o,
  // Error status
  output otp_lci_pkg::otp_err_e  error_o,
  output logic                   fsm_err_o,
  output logic                   lci_prog_idle_o,
  // Write port toward the array
  output logic                   otp_req_o,
  output otp_lci_pkg::otp_addr_t otp_addr_o,
  output otp_lci_pkg::otp_word_t otp_wdata_o,
  input  logic                   otp_gnt_i,
  input  logic                   otp_rvalid_i,
  input  otp_lci_pkg::otp_err_e  otp_err_i
);

  import otp_lci_pkg::*;

  lci_state_e state_d, state_q;
  otp_err_e   error_d, error_q;

  // Word counter control and status
  logic                cnt_clr;
  logic                cnt_incr;
  logic                cnt_err;
  logic [CntWidth-1:0] cnt;

  // Loose test of the escalation code
  logic esc_active;

  assign esc_active = (escalate_en_i != LcTxOff);
  assign error_o    = error_q;

  ////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////

  always_comb begin : p_fsm
    state_d         = state_q;
    error_d         = error_q;
    cnt_clr         = 1'b0;
    cnt_incr        = 1'b0;
    lci_prog_idle_o = 1'b1;
    otp_req_o       = 1'b0;
    lc_ack_o        = 1'b0;
    lc_err_o        = 1'b0;
    fsm_err_o       = 1'b0;

    case (state_q)
      // Wait for the enable after reset
      ResetSt: begin
        lci_prog_idle_o = 1'b0;
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end

      // Wait for a transition request
      IdleSt: begin
        if (lc_req_i) begin
          state_d = WriteSt;
          cnt_clr = 1'b1;
        end
      end

      // Issue the write of word cnt
      // A low grant holds address and data
      WriteSt: begin
        lci_prog_idle_o = 1'b0;
        otp_req_o       = 1'b1;
        if (otp_gnt_i) begin
          state_d = WriteWaitSt;
        end
      end

      // Wait for the array response of the current word
      WriteWaitSt: begin
        lci_prog_idle_o = 1'b0;
        if (otp_rvalid_i) begin
          // Keep the latest failure but go on with the remaining words
          if (otp_err_i != NoError) begin
            error_d = otp_err_i;
          end
          if (cnt == CntWidth'(NumLcWords - 1)) begin
            // Last word done
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            if (error_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end else begin
            cnt_incr = 1'b1;
            state_d  = WriteSt;
          end
        end
      end

      // Terminal state that keeps the partition locked
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end

      // Unknown state code
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
    endcase

    // Escalation and counter mismatch override every state
    // Only the entry into ErrorSt pulses fsm_err_o
    if ((esc_active || cnt_err) && (state_q != ErrorSt)) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (error_q == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  ////////////////////////////////////////
  // Word counter and write data
  ////////////////////////////////////////

  otp_lci_word_cnt u_word_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clr_i  (cnt_clr),
    .incr_i (cnt_incr),
    .cnt_o  (cnt),
    .err_o  (cnt_err)
  );

  // Life cycle words are placed from LcOffset upward
  assign otp_addr_o = otp_addr_t'(LcOffset) + otp_addr_t'(cnt);

  // Zero on the bus unless a write is requested
  assign otp_wdata_o = otp_req_o ? lc_data_i[OtpWidth*cnt +: OtpWidth] : '0;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

endmodule : otp_lci_fsm

`default_nettype wire

/* verilog/otp_lci_pkg.sv */
// Shared widths, partition placement, escalation code and enums for the OTP life cycle path
`default_nettype none

package otp_lci_pkg;

  ////////////////////////////////////////
  // Array geometry
  ////////////////////////////////////////

  // Native OTP word width in bits
  localparam int OtpWidth = 16;
  // Number of native words in the array
  localparam int OtpDepth = 32;
  // Word address width
  localparam int OtpAddrWidth = 5;
  // Cycles from a grant to its response
  localparam int OtpRespLatency = 2;

  ////////////////////////////////////////
  // Life cycle partition
  ////////////////////////////////////////

  // Word address of the first life cycle word
  localparam int LcOffset = 8;
  // Native words that make up the life cycle state
  localparam int NumLcWords = 4;
  // Width of the transition data block
  localparam int LcDataWidth = NumLcWords * OtpWidth;
  // Word counter width that holds NumLcWords
  localparam int CntWidth = 2;

  // One native OTP word
  typedef logic [OtpWidth-1:0] otp_word_t;
  // Native word address
  typedef logic [OtpAddrWidth-1:0] otp_addr_t;
  // Transition data with word k at bits 16k upward
  typedef logic [LcDataWidth-1:0] lc_data_t;

  ////////////////////////////////////////
  // Escalation
  ////////////////////////////////////////

  // Multi-bit life cycle signal
  typedef logic [3:0] lc_tx_t;

  // Anything other than LcTxOff counts as active
  localparam lc_tx_t LcTxOn  = 4'b0101;
  localparam lc_tx_t LcTxOff = 4'b1010;

  ////////////////////////////////////////
  // Error codes and FSM encoding
  ////////////////////////////////////////

  // Error codes of the array and of the controller
  typedef enum logic [1:0] {
    NoError              = 2'h0,
    MacroWriteBlankError = 2'h1,
    FsmStateError        = 2'h2
  } otp_err_e;

  // Sparse controller states
  // Minimum Hamming distance between any two codes is 5
  typedef enum logic [8:0] {
    ResetSt     = 9'b000101011,
    IdleSt      = 9'b110011110,
    WriteSt     = 9'b101010001,
    WriteWaitSt = 9'b010000000,
    ErrorSt     = 9'b011111101
  } lci_state_e;

endpackage : otp_lci_pkg

`default_nettype wire

/* verilog/otp_lci_top.sv */
// Top level of the life cycle programming path that joins the controller FSM to the OTP array model
`default_nettype none
`timescale 1ns/1ps

module otp_lci_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   lci_en_i,
  input  otp_lci_pkg::lc_tx_t    escalate_en_i,
  // Life cycle transition handshake
  input  logic                   lc_req_i,
  input  otp_lci_pkg::lc_data_t  lc_data_i,
  output logic                   lc_ack_o,
  output logic                   lc_err_o,
  // Status
  output otp_lci_pkg::otp_err_e  error_o,
  output logic                   fsm_err_o,
  output logic                   lci_prog_idle_o,
  // Debug read of the array
  input  otp_lci_pkg::otp_addr_t dbg_addr_i,
  output otp_lci_pkg::otp_word_t dbg_rdata_o
);

  import otp_lci_pkg::*;

  // Write port between controller and array
  logic      otp_req;
  logic      otp_gnt;
  logic      otp_rvalid;
  otp_addr_t otp_addr;
  otp_word_t otp_wdata;
  otp_err_e  otp_err;

  otp_lci_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lci_en_i        (lci_en_i),
    .escalate_en_i   (escalate_en_i),
    .lc_req_i        (lc_req_i),
    .lc_data_i       (lc_data_i),
    .lc_ack_o        (lc_ack_o),
    .lc_err_o        (lc_err_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .lci_prog_idle_o (lci_prog_idle_o),
    .otp_req_o       (otp_req),
    .otp_addr_o      (otp_addr),
    .otp_wdata_o     (otp_wdata),
    .otp_gnt_i       (otp_gnt),
    .otp_rvalid_i    (otp_rvalid),
    .otp_err_i       (otp_err)
  );

  otp_array u_array (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (otp_req),
    .gnt_o       (otp_gnt),
    .addr_i      (otp_addr),
    .wdata_i     (otp_wdata),
    .rvalid_o    (otp_rvalid),
    .err_o       (otp_err),
    .dbg_addr_i  (dbg_addr_i),
    .dbg_rdata_o (dbg_rdata_o)
  );

endmodule : otp_lci_top

`default_nettype wire

/* verilog/otp_lci_word_cnt.sv */
// Redundant native-word counter for the life cycle FSM that flags any disagreement of its copies
`default_nettype none
`timescale 1ns/1ps

module otp_lci_word_cnt (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clr_i,
  input  logic                            incr_i,
  output logic [otp_lci_pkg::CntWidth-1:0] cnt_o,
  output logic                            err_o
);

  import otp_lci_pkg::*;

  // Up count and its down-counting mirror
  logic [CntWidth-1:0] up_q;
  logic [CntWidth-1:0] dn_q;
  // Sum of both copies is all ones when they agree
  logic [CntWidth-1:0] sum;

  ////////////////////////////////////////
  // Counter registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      up_q <= '0;
      dn_q <= '1;
    end else if (clr_i) begin
      // Restart both copies for a new transfer
      up_q <= '0;
      dn_q <= '1;
    end else if (incr_i) begin
      up_q <= up_q + 1'b1;
      dn_q <= dn_q - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Consistency check
  ////////////////////////////////////////

  // Wraps within CntWidth bits
  assign sum = up_q + dn_q;

  // A glitch on either register breaks the all-ones sum
  assign err_o = (sum != {CntWidth{1'b1}});

  assign cnt_o = up_q;

endmodule : otp_lci_word_cnt

`default_nettype wire
